// ==== include/zx_settings.svh ====
// ==============================
// Bus, page and flat address widths,
// I/O port numbers with decode masks,
// and beeper sample weights
// ==============================

`ifndef ZX_SETTINGS_SVH
`define ZX_SETTINGS_SVH

// Bus and memory widths
`define ZX_ADDR_W       16
`define ZX_DATA_W       8
`define ZX_PAGE_W       3
`define ZX_ROM_PAGE_W   2
`define ZX_MEM_ADDR_W   18

// Partially decoded ports, compared under their masks
`define ZX_PORT_FE      16'h00FE
`define ZX_MASK_FE      16'h0001
`define ZX_PORT_7FFD    16'h7FFD
`define ZX_MASK_7FFD    16'h8002
`define ZX_MASK_7FFD_P3 16'hC002
`define ZX_PORT_1FFD    16'h1FFD
`define ZX_MASK_1FFD    16'hF002

// Beeper contributions, summed into one 16-bit sample
`define ZX_BEEP_EAR     16'h2000
`define ZX_BEEP_MIC     16'h1000
`define ZX_BEEP_TAPE    16'h0800

`endif

// ==== rtl/zx_bus_pkg.sv ====
// ==============================
// CPU bus side types: machine model
// and the port FE read layout
// ==============================

package zx_bus_pkg;

	// Machine model, latched while reset is held
	typedef enum logic [1:0] {
		MODEL_48K   = 2'd0,
		MODEL_128K  = 2'd1,
		MODEL_PLUS3 = 2'd2
	} machine_model_e;

	// ==============================
	// Port FE read word
	// ==============================
	// Bits 7 and 5 always read high
	// Tape input comes back inverted
	// Key columns are active low, straight from the matrix
	typedef struct packed {
		logic       one_hi;
		logic       tape_n;
		logic       one_lo;
		logic [4:0] keys;
	} ula_read_t;

	// Helper to assemble the read word
	function automatic ula_read_t ula_read_word(input logic [4:0] keys, input logic tape);
		ula_read_t w;
		w.one_hi = 1'b1;
		w.tape_n = ~tape;
		w.one_lo = 1'b1;
		w.keys   = keys;
		return w;
	endfunction

endpackage

// ==== rtl/zx_paging_pkg.sv ====
// ==============================
// Paging register layouts: 7FFD struct
// and 1FFD union with its two views
// ==============================

`include "zx_settings.svh"

package zx_paging_pkg;

	// ==============================
	// Port 7FFD
	// ==============================
	// Bits 7..6 are don't care on the 128K and +3
	typedef struct packed {
		logic [1:0]            spare;
		logic                  lock;
		logic                  rom_lo;
		logic                  screen;
		logic [`ZX_PAGE_W-1:0] ram_page;
	} page_7ffd_t;

	// ==============================
	// Port 1FFD (+3 only)
	// ==============================
	// Bit 0 picks how bits 2..1 are read

	// Normal paging: bit 2 is the high ROM select, bit 1 drives no paging
	typedef struct packed {
		logic [4:0] unused_hi;
		logic       rom_hi;
		logic       unused;
		logic       special;
	} page_1ffd_normal_t;

	// All-RAM paging: bits 2..1 choose one of four slot layouts
	typedef struct packed {
		logic [4:0] unused_hi;
		logic [1:0] cfg;
		logic       special;
	} page_1ffd_special_t;

	typedef union packed {
		page_1ffd_normal_t  normal;
		page_1ffd_special_t spec;
	} page_1ffd_u;

endpackage

// ==== rtl/zx_io_ports.sv ====
// ==============================
// I/O write strobe, ULA port FE,
// beeper sample and CPU read mux
// ==============================

`timescale 1ns/10ps

`include "zx_settings.svh"

module zx_io_ports import zx_bus_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,

	// CPU bus
	input  logic [`ZX_ADDR_W-1:0] cpu_addr,
	input  logic [`ZX_DATA_W-1:0] cpu_dout,
	input  logic                  mem_req,
	input  logic                  io_req,
	input  logic                  rd,
	input  logic                  wr,
	input  logic                  m1,

	// Keyboard, tape and memory read data
	input  logic [4:0]            key_data,
	input  logic                  tape_in,
	input  logic [`ZX_DATA_W-1:0] mem_rdata,

	output logic                  io_wr_stb,
	output logic [`ZX_DATA_W-1:0] cpu_din,
	output logic [2:0]            border_color,
	output logic                  ear_out,
	output logic                  mic_out,
	output logic [15:0]           beeper
);

	logic      io_wr;
	logic      io_rd;
	logic      io_wr_q;
	logic      ula_sel;
	ula_read_t ula_word;

	// ==============================
	// I/O write strobe
	// ==============================
	// M1 together with IORQ is an interrupt acknowledge, not a port access
	assign io_wr = io_req & wr & ~m1;
	assign io_rd = io_req & rd & ~m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// High only in the first sampled cycle of each write
	assign io_wr_stb = io_wr & ~io_wr_q;

	// ==============================
	// ULA port FE
	// ==============================
	// Any even address reaches the ULA
	assign ula_sel = ((cpu_addr & `ZX_MASK_FE) == (`ZX_PORT_FE & `ZX_MASK_FE));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr_stb && ula_sel) begin
			border_color <= cpu_dout[2:0];
			ear_out      <= cpu_dout[4];
			mic_out      <= cpu_dout[3];
		end
	end

	// Weighted sum of the three one-bit sources
	always_comb begin
		beeper = 16'h0000;
		if (ear_out)
			beeper = beeper + `ZX_BEEP_EAR;
		if (mic_out)
			beeper = beeper + `ZX_BEEP_MIC;
		if (tape_in)
			beeper = beeper + `ZX_BEEP_TAPE;
	end

	// ==============================
	// CPU read data
	// ==============================
	assign ula_word = ula_read_word(key_data, tape_in);

	// Memory first, then port FE, idle bus floats high
	always_comb begin
		if (mem_req && rd)
			cpu_din = mem_rdata;
		else if (io_rd && ula_sel)
			cpu_din = ula_word;
		else
			cpu_din = 8'hFF;
	end

endmodule

// ==== rtl/zx_paging_regs.sv ====
// ==============================
// Model latch, 7FFD and 1FFD registers
// with lock, and derived page numbers
// ==============================

`timescale 1ns/10ps

`include "zx_settings.svh"

module zx_paging_regs import zx_bus_pkg::*, zx_paging_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  machine_model_e            model,

	input  logic [`ZX_ADDR_W-1:0]     cpu_addr,
	input  logic [`ZX_DATA_W-1:0]     cpu_dout,
	input  logic                      io_wr_stb,

	output logic [`ZX_ROM_PAGE_W-1:0] rom_page,
	output logic [`ZX_PAGE_W-1:0]     ram_page,
	output logic                      special,
	output logic [1:0]                special_cfg,
	output logic                      screen_page
);

	machine_model_e model_q;
	page_7ffd_t     p7ffd;
	page_1ffd_u     p1ffd;

	logic is_48k;
	logic is_plus3;
	logic page_disable;
	logic sel_7ffd;
	logic sel_1ffd;

	assign is_48k   = (model_q == MODEL_48K);
	assign is_plus3 = (model_q == MODEL_PLUS3);

	// Lock bit stays set until the next reset
	assign page_disable = is_48k | p7ffd.lock;

	// ==============================
	// Port decode
	// ==============================
	// The +3 also needs A14 high so 7FFD and 1FFD never overlap
	always_comb begin
		if (is_plus3)
			sel_7ffd = ((cpu_addr & `ZX_MASK_7FFD_P3) == (`ZX_PORT_7FFD & `ZX_MASK_7FFD_P3));
		else
			sel_7ffd = ((cpu_addr & `ZX_MASK_7FFD) == (`ZX_PORT_7FFD & `ZX_MASK_7FFD));
	end

	assign sel_1ffd = is_plus3 &
		((cpu_addr & `ZX_MASK_1FFD) == (`ZX_PORT_1FFD & `ZX_MASK_1FFD));

	// ==============================
	// Registers
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model;
			p7ffd   <= '0;
			p1ffd   <= '0;
		end else if (io_wr_stb && !page_disable) begin
			if (sel_7ffd)
				p7ffd <= page_7ffd_t'(cpu_dout);
			else if (sel_1ffd)
				p1ffd <= page_1ffd_u'(cpu_dout);
		end
	end

	// ==============================
	// Derived pages
	// ==============================
	// 48K always sees the BASIC ROM
	always_comb begin
		case (model_q)
			MODEL_128K:  rom_page = {1'b0, p7ffd.rom_lo};
			MODEL_PLUS3: rom_page = {p1ffd.normal.rom_hi, p7ffd.rom_lo};
			default:     rom_page = 2'd1;
		endcase
	end

	assign ram_page = is_48k ? '0 : p7ffd.ram_page;

	// Same 1FFD word read through its all-RAM view
	assign special     = p1ffd.spec.special;
	assign special_cfg = p1ffd.spec.cfg;

	assign screen_page = p7ffd.screen;

endmodule

// ==== rtl/zx_mem_map.sv ====
// ==============================
// CPU address to flat ROM/RAM address,
// read and write strobes
// ==============================

`timescale 1ns/10ps

`include "zx_settings.svh"

module zx_mem_map (
	input  logic [`ZX_ADDR_W-1:0]     cpu_addr,
	input  logic [`ZX_DATA_W-1:0]     cpu_dout,
	input  logic                      mem_req,
	input  logic                      rd,
	input  logic                      wr,

	input  logic [`ZX_ROM_PAGE_W-1:0] rom_page,
	input  logic [`ZX_PAGE_W-1:0]     ram_page,
	input  logic                      special,
	input  logic [1:0]                special_cfg,

	output logic [`ZX_MEM_ADDR_W-1:0] mem_addr,
	output logic                      mem_rd,
	output logic                      mem_we,
	output logic [`ZX_DATA_W-1:0]     mem_wdata
);

	logic [1:0]            slot;
	logic [13:0]           offset;
	logic [`ZX_PAGE_W-1:0] spec_page;

	assign slot   = cpu_addr[15:14];
	assign offset = cpu_addr[13:0];

	// ==============================
	// All-RAM slot layouts
	// ==============================
	always_comb begin
		case (special_cfg)
			2'd0: spec_page = {1'b0, slot};
			2'd1: spec_page = {1'b1, slot};
			2'd2: spec_page = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
			default: begin
				// 4 7 6 3
				if (slot == 2'd3)
					spec_page = 3'd3;
				else if (slot == 2'd1)
					spec_page = 3'd7;
				else
					spec_page = {1'b1, slot};
			end
		endcase
	end

	// ==============================
	// Flat address
	// ==============================
	// Bit 17 marks ROM, then ROM page in 15..14
	always_comb begin
		if (special)
			mem_addr = {1'b0, spec_page, offset};
		else begin
			case (slot)
				2'd0:    mem_addr = {1'b1, 1'b0, rom_page, offset};
				2'd1:    mem_addr = {1'b0, 3'd5, offset};
				2'd2:    mem_addr = {1'b0, 3'd2, offset};
				default: mem_addr = {1'b0, ram_page, offset};
			endcase
		end
	end

	// ROM in slot 0 is write protected
	assign mem_rd    = mem_req & rd;
	assign mem_we    = mem_req & wr & (special | (slot != 2'd0));
	assign mem_wdata = cpu_dout;

endmodule

// ==== rtl/zx_glue.sv ====
// ==============================
// Spectrum CPU-side glue top level:
// I/O ports, paging registers and
// memory map
// ==============================

`timescale 1ns/10ps

`include "zx_settings.svh"

module zx_glue import zx_bus_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  machine_model_e            model,

	// CPU bus
	input  logic [`ZX_ADDR_W-1:0]     cpu_addr,
	input  logic [`ZX_DATA_W-1:0]     cpu_dout,
	input  logic                      mem_req,
	input  logic                      io_req,
	input  logic                      rd,
	input  logic                      wr,
	input  logic                      m1,
	output logic [`ZX_DATA_W-1:0]     cpu_din,

	// Keyboard and tape
	input  logic [4:0]                key_data,
	input  logic                      tape_in,

	// Flat ROM/RAM
	input  logic [`ZX_DATA_W-1:0]     mem_rdata,
	output logic [`ZX_MEM_ADDR_W-1:0] mem_addr,
	output logic                      mem_rd,
	output logic                      mem_we,
	output logic [`ZX_DATA_W-1:0]     mem_wdata,

	// ULA side
	output logic [2:0]                border_color,
	output logic                      ear_out,
	output logic                      mic_out,
	output logic [15:0]               beeper,
	output logic                      screen_page
);

	logic                      io_wr_stb;
	logic [`ZX_ROM_PAGE_W-1:0] rom_page;
	logic [`ZX_PAGE_W-1:0]     ram_page;
	logic                      special;
	logic [1:0]                special_cfg;

	zx_io_ports u_io_ports (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.mem_req      (mem_req),
		.io_req       (io_req),
		.rd           (rd),
		.wr           (wr),
		.m1           (m1),
		.key_data     (key_data),
		.tape_in      (tape_in),
		.mem_rdata    (mem_rdata),
		.io_wr_stb    (io_wr_stb),
		.cpu_din      (cpu_din),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.beeper       (beeper)
	);

	zx_paging_regs u_paging_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model       (model),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.io_wr_stb   (io_wr_stb),
		.rom_page    (rom_page),
		.ram_page    (ram_page),
		.special     (special),
		.special_cfg (special_cfg),
		.screen_page (screen_page)
	);

	zx_mem_map u_mem_map (
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.mem_req     (mem_req),
		.rd          (rd),
		.wr          (wr),
		.rom_page    (rom_page),
		.ram_page    (ram_page),
		.special     (special),
		.special_cfg (special_cfg),
		.mem_addr    (mem_addr),
		.mem_rd      (mem_rd),
		.mem_we      (mem_we),
		.mem_wdata   (mem_wdata)
	);

endmodule

// ==== verification/tb_zx_glue.sv ====
// ==============================
// Testbench for the Spectrum glue:
// directed paging, memory map and
// ULA port tests
// ==============================

`timescale 1ns/10ps

`include "zx_settings.svh"

module tb_zx_glue import zx_bus_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RST_C      = 12;
	localparam int IO_C       = 3;
	localparam int MEM_C      = 2;
	localparam int RAND_ITER  = 16;
	// Cycle count of all tests in run order
	localparam int TEST_CYCLES = (RST_C + IO_C + 8 * MEM_C) + (2 * RST_C + 4 * IO_C + 5 * MEM_C)
		+ (RST_C + 4 * (2 * IO_C + 2 * MEM_C)) + (RST_C + 4 * (IO_C + 8 * MEM_C))
		+ (RST_C + 6 * IO_C) + 3 * (RST_C + RAND_ITER * (2 * IO_C + 4 * MEM_C));
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD + 1000;

	logic           clk_sys;
	logic           reset;
	machine_model_e model;
	logic [15:0]    cpu_addr;
	logic [7:0]     cpu_dout;
	logic           mem_req;
	logic           io_req;
	logic           rd;
	logic           wr;
	logic           m1;
	logic [4:0]     key_data;
	logic           tape_in;
	logic [7:0]     mem_rdata;
	logic [7:0]     cpu_din;
	logic [17:0]    mem_addr;
	logic           mem_rd;
	logic           mem_we;
	logic [7:0]     mem_wdata;
	logic [2:0]     border_color;
	logic           ear_out;
	logic           mic_out;
	logic [15:0]    beeper;
	logic           screen_page;

	// Expected paging state, kept from the port rules
	machine_model_e sh_model;
	logic [7:0]     sh_7ffd;
	logic [7:0]     sh_1ffd;
	logic [31:0]    rng_state;
	int             check_count;
	int             error_count;

	zx_glue dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: tests still running after %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	function automatic logic special_mode();
		return (sh_model == MODEL_PLUS3) && sh_1ffd[0];
	endfunction

	// ==============================
	// Reference memory map
	// ==============================
	function automatic logic [17:0] expected_mem_addr(input logic [15:0] addr);
		logic [1:0]  rom;
		logic [11:0] row;
		logic [17:0] res;
		// Special mode rows list slot 3 down to slot 0
		case (sh_1ffd[2:1])
			2'd0:    row = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    row = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    row = {3'd3, 3'd6, 3'd5, 3'd4};
			default: row = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		case (sh_model)
			MODEL_48K:  rom = 2'd1;
			MODEL_128K: rom = {1'b0, sh_7ffd[4]};
			default:    rom = {sh_1ffd[2], sh_7ffd[4]};
		endcase
		if (special_mode())
			res = {1'b0, row[addr[15:14] * 3 +: 3], addr[13:0]};
		else if (addr[15:14] == 2'd0)
			res = {2'b10, rom, addr[13:0]};
		else if (addr[15:14] == 2'd1)
			res = {1'b0, 3'd5, addr[13:0]};
		else if (addr[15:14] == 2'd2)
			res = {1'b0, 3'd2, addr[13:0]};
		else if (sh_model == MODEL_48K)
			res = {1'b0, 3'd0, addr[13:0]};
		else
			res = {1'b0, sh_7ffd[2:0], addr[13:0]};
		return res;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ==============================
	// Bus cycles
	// ==============================
	task automatic bus_idle();
		mem_req <= 1'b0;
		io_req  <= 1'b0;
		rd      <= 1'b0;
		wr      <= 1'b0;
		m1      <= 1'b0;
	endtask

	task automatic apply_reset(input machine_model_e m);
		@(posedge clk_sys);
		bus_idle();
		reset <= 1'b1;
		model <= m;
		repeat (10) @(posedge clk_sys);
		reset    <= 1'b0;
		sh_model = m;
		sh_7ffd  = 8'h00;
		sh_1ffd  = 8'h00;
	endtask

	// Held two cycles with the data inverted in the second one
	// Only a strobe in the first cycle keeps the intended value
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_dout <= data;
		io_req   <= 1'b1;
		wr       <= 1'b1;
		@(posedge clk_sys);
		cpu_dout <= ~data;
		@(posedge clk_sys);
		bus_idle();
	endtask

	task automatic io_read(input logic [15:0] addr, input logic [7:0] exp);
		@(posedge clk_sys);
		cpu_addr <= addr;
		io_req   <= 1'b1;
		rd       <= 1'b1;
		@(negedge clk_sys);
		check_eq("cpu_din", 32'(cpu_din), 32'(exp));
		@(posedge clk_sys);
		bus_idle();
	endtask

	task automatic write_7ffd(input logic [7:0] data);
		io_write(16'h7FFD, data);
		if (sh_model != MODEL_48K && !sh_7ffd[5])
			sh_7ffd = data;
	endtask

	task automatic write_1ffd(input logic [7:0] data);
		io_write(16'h1FFD, data);
		if (sh_model == MODEL_PLUS3 && !sh_7ffd[5])
			sh_1ffd = data;
	endtask

	task automatic mem_cycle(input logic [15:0] addr, input logic is_write);
		logic [31:0] r;
		logic        exp_we;
		next_random(r);
		// ROM in slot 0 takes no writes unless all-RAM mode is on
		exp_we = is_write && (addr[15:14] != 2'd0 || special_mode());
		@(posedge clk_sys);
		cpu_addr  <= addr;
		cpu_dout  <= r[7:0];
		mem_rdata <= r[15:8];
		mem_req   <= 1'b1;
		rd        <= !is_write;
		wr        <= is_write;
		@(negedge clk_sys);
		check_eq("mem_addr", 32'(mem_addr), 32'(expected_mem_addr(addr)));
		check_eq("mem_rd", 32'(mem_rd), 32'(!is_write));
		check_eq("mem_we", 32'(mem_we), 32'(exp_we));
		if (is_write)
			check_eq("mem_wdata", 32'(mem_wdata), 32'(r[7:0]));
		else
			check_eq("cpu_din", 32'(cpu_din), 32'(r[15:8]));
		@(posedge clk_sys);
		bus_idle();
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic test_48k_defaults();
		logic [31:0] r;
		apply_reset(MODEL_48K);
		write_7ffd(8'h1F);
		@(negedge clk_sys);
		check_eq("screen_page", 32'(screen_page), 32'd0);
		for (int s = 0; s < 4; s++) begin
			next_random(r);
			mem_cycle({2'(s), r[13:0]}, 1'b0);
			mem_cycle({2'(s), r[29:16]}, 1'b1);
		end
	endtask

	task automatic test_128k_paging();
		apply_reset(MODEL_128K);
		write_7ffd(8'h1B);
		@(negedge clk_sys);
		check_eq("screen_page", 32'(screen_page), 32'd1);
		mem_cycle(16'h0123, 1'b0);
		mem_cycle(16'hC456, 1'b1);
		// Page 4 with lock, then a write that must be dropped
		write_7ffd(8'h24);
		write_7ffd(8'h1F);
		@(negedge clk_sys);
		check_eq("screen_page", 32'(screen_page), 32'd0);
		mem_cycle(16'h0123, 1'b0);
		mem_cycle(16'hFEDC, 1'b1);
		apply_reset(MODEL_128K);
		write_7ffd(8'h06);
		mem_cycle(16'hC000, 1'b0);
	endtask

	task automatic test_plus3_rom();
		apply_reset(MODEL_PLUS3);
		for (int i = 0; i < 4; i++) begin
			write_1ffd({5'd0, i[1], 2'b00});
			write_7ffd({3'd0, i[0], 4'd0});
			mem_cycle({2'b00, 14'(i * 997)}, 1'b0);
			mem_cycle(16'h0ABC, 1'b1);
		end
	endtask

	task automatic test_plus3_special();
		logic [31:0] r;
		apply_reset(MODEL_PLUS3);
		for (int c = 0; c < 4; c++) begin
			write_1ffd({5'd0, 2'(c), 1'b1});
			for (int s = 0; s < 4; s++) begin
				next_random(r);
				mem_cycle({2'(s), r[13:0]}, 1'b0);
				mem_cycle({2'(s), r[27:14]}, 1'b1);
			end
		end
	endtask

	task automatic test_ula_port();
		apply_reset(MODEL_48K);
		tape_in  <= 1'b1;
		key_data <= 5'h15;
		io_write(16'h00FE, 8'h1D);
		@(negedge clk_sys);
		check_eq("border_color", 32'(border_color), 32'd5);
		check_eq("ear_out", 32'(ear_out), 32'd1);
		check_eq("mic_out", 32'(mic_out), 32'd1);
		check_eq("beeper", 32'(beeper), 32'(`ZX_BEEP_EAR + `ZX_BEEP_MIC + `ZX_BEEP_TAPE));
		// Bits 7 and 5 high, tape inverted in bit 6
		io_read(16'h12FE, {1'b1, 1'b0, 1'b1, 5'h15});
		io_read(16'h00FF, 8'hFF);
		tape_in  <= 1'b0;
		key_data <= 5'h0A;
		io_write(16'h34FE, 8'h0A);
		@(negedge clk_sys);
		check_eq("border_color", 32'(border_color), 32'd2);
		check_eq("ear_out", 32'(ear_out), 32'd0);
		check_eq("mic_out", 32'(mic_out), 32'd1);
		check_eq("beeper", 32'(beeper), 32'(`ZX_BEEP_MIC));
		io_read(16'hFFFE, {1'b1, 1'b1, 1'b1, 5'h0A});
	endtask

	task automatic test_random_mapping();
		logic [31:0] r;
		for (int m = 0; m < 3; m++) begin
			apply_reset(machine_model_e'(2'(m)));
			for (int i = 0; i < RAND_ITER; i++) begin
				next_random(r);
				// Lock stays clear so every pass can repage
				write_7ffd(r[7:0] & 8'hDF);
				if (m == 2)
					write_1ffd(r[15:8]);
				for (int k = 0; k < 4; k++) begin
					next_random(r);
					mem_cycle(r[15:0], r[16]);
				end
			end
		end
	endtask

	initial begin
		reset       = 1'b1;
		model       = MODEL_48K;
		cpu_addr    = 16'h0000;
		cpu_dout    = 8'h00;
		mem_req     = 1'b0;
		io_req      = 1'b0;
		rd          = 1'b0;
		wr          = 1'b0;
		m1          = 1'b0;
		key_data    = 5'h1F;
		tape_in     = 1'b0;
		mem_rdata   = 8'h00;
		sh_model    = MODEL_48K;
		sh_7ffd     = 8'h00;
		sh_1ffd     = 8'h00;
		rng_state   = 32'h9765_8be1;
		check_count = 0;
		error_count = 0;
		test_48k_defaults();
		test_128k_paging();
		test_plus3_rom();
		test_plus3_special();
		test_ula_port();
		test_random_mapping();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== zx_glue.f ====
+incdir+include
rtl/zx_bus_pkg.sv
rtl/zx_paging_pkg.sv
rtl/zx_io_ports.sv
rtl/zx_paging_regs.sv
rtl/zx_mem_map.sv
rtl/zx_glue.sv
verification/tb_zx_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f zx_glue.f --top-module tb_zx_glue \
	&& ./obj_dir/Vtb_zx_glue | tee /dev/stderr | grep -qx "Test passed" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
